// File: sources.f
hdl/vstu_pkg.sv
hdl/vstu_insn_queue.sv
hdl/vstu_beat_packer.sv
hdl/vstu_commit.sv
hdl/vstu_top.sv
bench/tb_clk_gen.sv
bench/vstu_chk.sv
bench/vstu_tb.sv

// File: Makefile
TOP := vstu_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f sources.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q ">>> PASS" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// File: bench/vstu_tb.sv
`default_nettype none

module vstu_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import vstu_pkg::*;

  localparam int unsigned NrReq = 40;

  // One expected write beat
  typedef struct packed {
    vinsn_id_t  id;
    beat_strb_t strb;
    lane_idx_t  lane;
    logic       tail;
    logic       word_end;
  } exp_beat_t;

  logic clk_i;
  logic rst_ni;

  // DUT inputs
  logic                req_valid_i;
  vinsn_id_t           req_id_i;
  vfu_op_e             req_op_i;
  vl_t                 req_vl_i;
  vsew_e               req_vsew_i;
  logic                ag_valid_i;
  burst_len_t          ag_len_i;
  elen_t [NrLanes-1:0] lane_operand_i;
  logic  [NrLanes-1:0] lane_valid_i;
  logic                w_ready_i;
  logic                b_valid_i;
  // DUT outputs
  logic                req_ready_o;
  logic                ag_ready_o;
  logic  [NrLanes-1:0] lane_ready_o;
  beat_data_t          w_data_o;
  beat_strb_t          w_strb_o;
  logic                w_last_o;
  logic                w_valid_o;
  logic                b_ready_o;
  logic                store_complete_o;
  logic                store_pending_o;
  logic  [NrVInsn-1:0] resp_done_o;

  // Reference model state
  logic [31:0]         seed = 32'h901b_95d2;
  exp_beat_t           beat_q [$];
  vinsn_id_t           retire_q [$];
  int unsigned         ag_q [$];
  elen_t [NrLanes-1:0] lane_words;
  logic  [NrVInsn-1:0] running = '0;
  logic  [NrVInsn-1:0] done_exp = '0;
  int unsigned         inflight = 0;
  int unsigned         burst_left = 0;
  int unsigned         ag_insn_left = 0;
  int unsigned         presented = 0;
  logic                req_pending = 1'b0;
  logic                finished = 1'b0;

  tb_clk_gen i_clk_gen (.clk_o(clk_i), .rst_no(rst_ni));

  vstu_top UUT (
    .clk_i(clk_i), .rst_ni(rst_ni),
    .req_valid_i(req_valid_i), .req_id_i(req_id_i), .req_op_i(req_op_i),
    .req_vl_i(req_vl_i), .req_vsew_i(req_vsew_i), .req_ready_o(req_ready_o),
    .ag_valid_i(ag_valid_i), .ag_len_i(ag_len_i), .ag_ready_o(ag_ready_o),
    .lane_operand_i(lane_operand_i), .lane_valid_i(lane_valid_i),
    .lane_ready_o(lane_ready_o),
    .w_data_o(w_data_o), .w_strb_o(w_strb_o), .w_last_o(w_last_o),
    .w_valid_o(w_valid_o), .w_ready_i(w_ready_i),
    .b_valid_i(b_valid_i), .b_ready_o(b_ready_o),
    .store_complete_o(store_complete_o), .store_pending_o(store_pending_o),
    .resp_done_o(resp_done_o)
  );

  bind vstu_top vstu_chk i_chk (
    .clk_i(clk_i), .rst_ni(rst_ni), .req_valid_i(req_valid_i), .req_op_i(req_op_i),
    .req_ready_o(req_ready_o), .lane_valid_i(lane_valid_i), .w_valid_o(w_valid_o),
    .w_last_o(w_last_o), .b_valid_i(b_valid_i), .store_complete_o(store_complete_o)
  );

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  // LCG step returning the upper half of the state
  function automatic logic [15:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed[31:16];
  endfunction

  function automatic elen_t rand_word();
    return {next_rand(), next_rand(), next_rand(), next_rand()};
  endfunction

  // Random id whose running state matches want_running
  function automatic vinsn_id_t pick_id(input logic want_running);
    vinsn_id_t id;
    id = vinsn_id_t'(next_rand());
    for (int unsigned k = 0; k < NrVInsn; k++) begin
      if (running[id] == want_running) begin
        return id;
      end
      id = id + 1'b1;
    end
    return id;
  endfunction

  task automatic abort_run(input string what);
    $display("%s", what);
    $display(">>> FAIL");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input beat_data_t got, input beat_data_t exp);
    if (got !== exp) abort_run($sformatf("ERR %0t %s got %h exp %h", $time, name, got, exp));
  endtask

  task automatic check_strb(input string name, input beat_strb_t got, input beat_strb_t exp);
    if (got !== exp) abort_run($sformatf("ERR %0t %s got %b exp %b", $time, name, got, exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) abort_run($sformatf("ERR %0t %s got %b exp %b", $time, name, got, exp));
  endtask

  task automatic check_done_vec(input string name, input logic [NrVInsn-1:0] got,
                                input logic [NrVInsn-1:0] exp);
    if (got !== exp) abort_run($sformatf("ERR %0t %s got %b exp %b", $time, name, got, exp));
  endtask

  // Expected beats of an accepted store with sequential bytes
  task automatic queue_store(input vinsn_id_t id, input vl_t vl, input vsew_e sew);
    int unsigned bytes;
    int unsigned beats;
    int unsigned rem;
    exp_beat_t   b;
    bytes = 32'(vl) << sew;
    beats = (bytes + BeatBytes - 1) / BeatBytes;
    for (int unsigned j = 0; j < beats; j++) begin
      rem        = bytes - j * BeatBytes;
      b.id       = id;
      b.strb     = (rem >= BeatBytes) ? '1 : beat_strb_t'((1 << rem) - 1);
      b.lane     = lane_idx_t'(j % NrLanes);
      b.tail     = (j == beats - 1);
      b.word_end = b.tail || (j % NrLanes == NrLanes - 1);
      beat_q.push_back(b);
    end
    ag_q.push_back(beats);
  endtask

  ////////////////////////////////////////
  // Model, checks and stimulus
  ////////////////////////////////////////

  always @(posedge clk_i) begin : model
    exp_beat_t   b;
    logic        fire;
    logic        last_exp;
    logic        lrdy_exp;
    logic        retire;
    logic        accept;
    logic        ready_exp;
    vinsn_id_t   rid;
    int unsigned len;
    logic [15:0] r;

    if (rst_ni && !finished) begin
      // Status seen in the cycle that ends here
      ready_exp = (inflight != QueueDepth);
      check_bit("req_ready_o", req_ready_o, ready_exp);
      check_bit("store_pending_o", store_pending_o, inflight != 0);
      check_bit("b_ready_o", b_ready_o, b_valid_i);
      check_done_vec("resp_done_o", resp_done_o, done_exp);
      // Acceptance uses the running ids before this edge
      accept = req_valid_i && ready_exp && (req_op_i == OP_STORE) && !running[req_id_i];

      // Write beat
      fire = w_ready_i && ag_valid_i && (&lane_valid_i) && (beat_q.size() != 0);
      check_bit("w_valid_o", w_valid_o, fire);
      last_exp = 1'b0;
      lrdy_exp = 1'b0;
      if (fire) begin
        b = beat_q.pop_front();
        check_data("w_data_o", w_data_o, lane_words[b.lane]);
        check_strb("w_strb_o", w_strb_o, b.strb);
        last_exp = (burst_left == 1);
        lrdy_exp = b.word_end;
        burst_left--;
        ag_insn_left--;
      end
      check_bit("w_last_o", w_last_o, last_exp);
      check_bit("ag_ready_o", ag_ready_o, last_exp);
      for (int unsigned l = 0; l < NrLanes; l++) begin
        check_bit("lane_ready_o", lane_ready_o[l], lrdy_exp);
      end

      // Response retires the oldest issued id if there is one
      retire = b_valid_i && (retire_q.size() != 0);
      check_bit("store_complete_o", store_complete_o, retire);
      done_exp = '0;
      if (retire) begin
        rid           = retire_q.pop_front();
        done_exp[rid] = 1'b1;
        running[rid]  = 1'b0;
      end
      // Id reaches the commit FIFO after its final beat
      if (fire && b.tail) retire_q.push_back(b.id);
      if (accept) begin
        running[req_id_i] = 1'b1;
        queue_store(req_id_i, req_vl_i, req_vsew_i);
      end
      inflight = inflight + 32'(accept) - 32'(retire);

      // Sequencer drops its request once ready was high
      if (req_pending && ready_exp) req_pending = 1'b0;
      if (!req_pending && presented < NrReq && next_rand() % 4 != 0) begin
        r = next_rand();
        req_op_i   <= (r % 12 == 0) ? OP_LOAD : OP_STORE;
        req_id_i   <= pick_id(r % 12 == 1);
        req_vl_i   <= vl_t'(1 + next_rand() % 40);
        req_vsew_i <= vsew_e'(next_rand() % 4);
        req_pending = 1'b1;
        presented++;
      end
      req_valid_i <= req_pending;

      // Address generator splits each store into random bursts with random gaps
      if (burst_left == 0 && next_rand() % 4 != 0) begin
        if (ag_insn_left == 0 && ag_q.size() != 0) ag_insn_left = ag_q.pop_front();
        if (ag_insn_left != 0) begin
          len        = 1 + next_rand() % ((ag_insn_left < 6) ? ag_insn_left : 6);
          burst_left = len;
          ag_len_i  <= burst_len_t'(len - 1);
        end
      end
      ag_valid_i <= (burst_left != 0);

      // New lane words once the current set is used up
      if (fire && b.word_end) begin
        for (int unsigned l = 0; l < NrLanes; l++) begin
          lane_words[l] = rand_word();
        end
        lane_operand_i <= lane_words;
      end
      r = next_rand();
      lane_valid_i <= (r[15:14] != 2'b00) ? '1 : r[NrLanes-1:0];
      w_ready_i    <= (next_rand() % 4 != 0);
      b_valid_i    <= (next_rand() % 3 == 0);

      finished = (presented == NrReq) && !req_pending && (inflight == 0);
    end
  end

  ////////////////////////////////////////
  // Start, end and watchdog
  ////////////////////////////////////////

  initial begin
    req_valid_i  <= 1'b0;
    req_id_i     <= '0;
    req_op_i     <= OP_STORE;
    req_vl_i     <= '0;
    req_vsew_i   <= SEW8;
    ag_valid_i   <= 1'b0;
    ag_len_i     <= '0;
    lane_valid_i <= '0;
    w_ready_i    <= 1'b0;
    b_valid_i    <= 1'b0;
    for (int unsigned l = 0; l < NrLanes; l++) begin
      lane_words[l] = rand_word();
    end
    lane_operand_i <= lane_words;
    wait (finished);
    $display(">>> PASS");
    $finish;
  end

  // 200 cycles of 10 ns per request
  initial begin
    #(NrReq * 200 * 10);
    abort_run("Timeout: the stores did not drain before the watchdog expired");
  end

endmodule

`default_nettype wire

// File: bench/vstu_chk.sv
`default_nettype none

module vstu_chk (
  input logic                           clk_i,
  input logic                           rst_ni,
  input logic                           req_valid_i,
  input vstu_pkg::vfu_op_e              req_op_i,
  input logic                           req_ready_o,
  input logic [vstu_pkg::NrLanes-1:0]   lane_valid_i,
  input logic                           w_valid_o,
  input logic                           w_last_o,
  input logic                           b_valid_i,
  input logic                           store_complete_o
);

  timeunit 1ns;
  timeprecision 100ps;

  import vstu_pkg::*;

  // Last flag only on a valid beat
  a_last_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    w_last_o |-> w_valid_o) else $error("w_last_o high without w_valid_o");

  // A beat needs every lane word
  a_lanes_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    w_valid_o |-> (&lane_valid_i)) else $error("w_valid_o with a lane not valid");

  // Completion only on a write response
  a_complete_resp: assert property (@(posedge clk_i) disable iff (!rst_ni)
    store_complete_o |-> b_valid_i) else $error("store_complete_o without b_valid_i");

  // Queue only fills up through an accepted store
  a_ready_fall: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $fell(req_ready_o) |-> $past(req_valid_i && (req_op_i == OP_STORE)))
    else $error("req_ready_o fell without an accepted store");

endmodule

`default_nettype wire

// File: bench/tb_clk_gen.sv
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  timeunit 1ns;
  timeprecision 100ps;

  // 10 ns period, first rising edge at 5 ns
  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Low over two rising edges, released on a falling edge
  initial begin
    rst_no = 1'b0;
    #20 rst_no = 1'b1;
  end

endmodule

`default_nettype wire

// File: hdl/vstu_top.sv
`default_nettype none

module vstu_top (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  // Sequencer
  input  logic                                    req_valid_i,
  input  vstu_pkg::vinsn_id_t                     req_id_i,
  input  vstu_pkg::vfu_op_e                       req_op_i,
  input  vstu_pkg::vl_t                           req_vl_i,
  input  vstu_pkg::vsew_e                         req_vsew_i,
  output logic                                    req_ready_o,
  // Address generator
  input  logic                                    ag_valid_i,
  input  vstu_pkg::burst_len_t                    ag_len_i,
  output logic                                    ag_ready_o,
  // Lanes
  input  vstu_pkg::elen_t [vstu_pkg::NrLanes-1:0] lane_operand_i,
  input  logic            [vstu_pkg::NrLanes-1:0] lane_valid_i,
  output logic            [vstu_pkg::NrLanes-1:0] lane_ready_o,
  // Write data channel
  output vstu_pkg::beat_data_t                    w_data_o,
  output vstu_pkg::beat_strb_t                    w_strb_o,
  output logic                                    w_last_o,
  output logic                                    w_valid_o,
  input  logic                                    w_ready_i,
  // Write response channel
  input  logic                                    b_valid_i,
  output logic                                    b_ready_o,
  // Status
  output logic                                    store_complete_o,
  output logic                                    store_pending_o,
  output logic            [vstu_pkg::NrVInsn-1:0] resp_done_o
);

  import vstu_pkg::*;

  // Queue head to packer
  logic      issue_valid;
  vinsn_id_t issue_id;
  byte_cnt_t issue_bytes;
  // Packer to queue and commit
  logic      issue_done;
  vinsn_id_t done_id;
  // Commit back to queue
  logic      commit;
  vinsn_id_t commit_id;

  ////////////////////////////////////////
  // Decode
  ////////////////////////////////////////

  vstu_insn_queue i_insn_queue (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_valid_i     (req_valid_i),
    .req_id_i        (req_id_i),
    .req_op_i        (req_op_i),
    .req_vl_i        (req_vl_i),
    .req_vsew_i      (req_vsew_i),
    .req_ready_o     (req_ready_o),
    .issue_valid_o   (issue_valid),
    .issue_id_o      (issue_id),
    .issue_bytes_o   (issue_bytes),
    .issue_done_i    (issue_done),
    .commit_i        (commit),
    .commit_id_i     (commit_id),
    .store_pending_o (store_pending_o)
  );

  ////////////////////////////////////////
  // Execute
  ////////////////////////////////////////

  vstu_beat_packer i_beat_packer (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .issue_valid_i  (issue_valid),
    .issue_id_i     (issue_id),
    .issue_bytes_i  (issue_bytes),
    .issue_done_o   (issue_done),
    .done_id_o      (done_id),
    .ag_valid_i     (ag_valid_i),
    .ag_len_i       (ag_len_i),
    .ag_ready_o     (ag_ready_o),
    .lane_operand_i (lane_operand_i),
    .lane_valid_i   (lane_valid_i),
    .lane_ready_o   (lane_ready_o),
    .w_data_o       (w_data_o),
    .w_strb_o       (w_strb_o),
    .w_last_o       (w_last_o),
    .w_valid_o      (w_valid_o),
    .w_ready_i      (w_ready_i)
  );

  ////////////////////////////////////////
  // Result
  ////////////////////////////////////////

  vstu_commit i_commit (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .issue_done_i     (issue_done),
    .done_id_i        (done_id),
    .b_valid_i        (b_valid_i),
    .b_ready_o        (b_ready_o),
    .commit_o         (commit),
    .commit_id_o      (commit_id),
    .store_complete_o (store_complete_o),
    .resp_done_o      (resp_done_o)
  );

endmodule

`default_nettype wire

// File: hdl/vstu_commit.sv
`default_nettype none

module vstu_commit (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  // Ids that finished issuing
  input  logic                             issue_done_i,
  input  vstu_pkg::vinsn_id_t              done_id_i,
  // Write response
  input  logic                             b_valid_i,
  output logic                             b_ready_o,
  // Retire towards the queue and the sequencer
  output logic                             commit_o,
  output vstu_pkg::vinsn_id_t              commit_id_o,
  output logic                             store_complete_o,
  output logic [vstu_pkg::NrVInsn-1:0]     resp_done_o
);

  import vstu_pkg::*;

  ////////////////////////////////////////
  // Id FIFO
  ////////////////////////////////////////

  vinsn_id_t fifo_q [QueueDepth];
  qidx_t     wr_pnt_q;
  qidx_t     rd_pnt_q;
  qcnt_t     cnt_q;

  logic               pop;
  logic [NrVInsn-1:0] done_d;

  // Every response is taken, even with nothing to retire
  assign b_ready_o = b_valid_i;

  // Oldest issued id retires on a response
  assign pop              = b_valid_i && (cnt_q != '0);
  assign commit_o         = pop;
  assign commit_id_o      = fifo_q[rd_pnt_q];
  assign store_complete_o = pop;

  always_ff @(posedge clk_i) begin
    if (issue_done_i) begin
      fifo_q[wr_pnt_q] <= done_id_i;
    end
  end

  // One-hot pulse at the retired id
  always_comb begin
    done_d = '0;
    if (pop) begin
      done_d[commit_id_o] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_pnt_q    <= '0;
      rd_pnt_q    <= '0;
      cnt_q       <= '0;
      resp_done_o <= '0;
    end else begin
      if (issue_done_i) begin
        wr_pnt_q <= wr_pnt_q + 1'b1;
      end
      if (pop) begin
        rd_pnt_q <= rd_pnt_q + 1'b1;
      end
      cnt_q       <= cnt_q + qcnt_t'(issue_done_i) - qcnt_t'(pop);
      resp_done_o <= done_d;
    end
  end

endmodule

`default_nettype wire

// File: hdl/vstu_beat_packer.sv
`default_nettype none

module vstu_beat_packer (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  // Issue head from the queue
  input  logic                                       issue_valid_i,
  input  vstu_pkg::vinsn_id_t                        issue_id_i,
  input  vstu_pkg::byte_cnt_t                        issue_bytes_i,
  output logic                                       issue_done_o,
  output vstu_pkg::vinsn_id_t                        done_id_o,
  // Address generator
  input  logic                                       ag_valid_i,
  input  vstu_pkg::burst_len_t                       ag_len_i,
  output logic                                       ag_ready_o,
  // Lane operands
  input  vstu_pkg::elen_t [vstu_pkg::NrLanes-1:0]    lane_operand_i,
  input  logic            [vstu_pkg::NrLanes-1:0]    lane_valid_i,
  output logic            [vstu_pkg::NrLanes-1:0]    lane_ready_o,
  // Write channel
  output vstu_pkg::beat_data_t                       w_data_o,
  output vstu_pkg::beat_strb_t                       w_strb_o,
  output logic                                       w_last_o,
  output logic                                       w_valid_o,
  input  logic                                       w_ready_i
);

  import vstu_pkg::*;

  // PH_IDLE means the count is still taken from the queue head
  pack_phase_e phase_q, phase_d;
  // Bytes left from the start of the current lane word set
  byte_cnt_t   rem_q, rem_d;
  // Lane that feeds the next beat
  lane_idx_t   word_pnt_q, word_pnt_d;
  // Beats already sent in the current burst
  burst_len_t  beat_cnt_q, beat_cnt_d;

  byte_cnt_t rem_cur;
  byte_cnt_t beat_rem;
  logic      beat_fire;
  logic      beat_final;
  logic      word_done;
  logic      burst_last;

  ////////////////////////////////////////
  // Beat framing
  ////////////////////////////////////////

  assign rem_cur  = (phase_q == PH_IDLE) ? issue_bytes_i : rem_q;
  // Bytes left for this beat onwards
  assign beat_rem = rem_cur - byte_cnt_t'(word_pnt_q) * byte_cnt_t'(BeatBytes);

  assign beat_final = (beat_rem <= byte_cnt_t'(BeatBytes));
  // Four beats per word set, or the tail of the instruction
  assign word_done  = beat_final || (word_pnt_q == lane_idx_t'(NrLanes - 1));
  assign burst_last = (beat_cnt_q == ag_len_i);

  // Sink, burst and every lane must be ready together
  assign w_valid_o = w_ready_i && issue_valid_i && ag_valid_i && (&lane_valid_i);
  assign beat_fire = w_valid_o && w_ready_i;

  // Sequential byte map, so beat j is simply lane j of the set
  assign w_data_o = lane_operand_i[word_pnt_q];

  // Low bytes only on a partial final beat
  always_comb begin
    for (int unsigned b = 0; b < BeatBytes; b++) begin
      w_strb_o[b] = (beat_rem > byte_cnt_t'(b));
    end
  end

  assign w_last_o     = beat_fire && burst_last;
  assign ag_ready_o   = beat_fire && burst_last;
  assign lane_ready_o = {NrLanes{beat_fire && word_done}};
  assign issue_done_o = beat_fire && beat_final;
  assign done_id_o    = issue_id_i;

  ////////////////////////////////////////
  // Next state
  ////////////////////////////////////////

  always_comb begin
    phase_d    = phase_q;
    rem_d      = rem_q;
    word_pnt_d = word_pnt_q;
    beat_cnt_d = beat_cnt_q;

    // Stalls leave everything where it is
    if (beat_fire) begin
      beat_cnt_d = burst_last ? '0 : beat_cnt_q + 1'b1;

      if (beat_final) begin
        // Ready for the next head right away
        phase_d    = PH_IDLE;
        rem_d      = '0;
        word_pnt_d = '0;
      end else begin
        phase_d = PH_STREAM;
        if (word_done) begin
          // Move on to the next lane word set
          rem_d      = rem_cur - byte_cnt_t'(WordBytes);
          word_pnt_d = '0;
        end else begin
          rem_d      = rem_cur;
          word_pnt_d = word_pnt_q + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      phase_q    <= PH_IDLE;
      rem_q      <= '0;
      word_pnt_q <= '0;
      beat_cnt_q <= '0;
    end else begin
      phase_q    <= phase_d;
      rem_q      <= rem_d;
      word_pnt_q <= word_pnt_d;
      beat_cnt_q <= beat_cnt_d;
    end
  end

endmodule

`default_nettype wire

// File: hdl/vstu_insn_queue.sv
`default_nettype none

module vstu_insn_queue (
  input  logic                clk_i,
  input  logic                rst_ni,
  // Sequencer requests
  input  logic                req_valid_i,
  input  vstu_pkg::vinsn_id_t req_id_i,
  input  vstu_pkg::vfu_op_e   req_op_i,
  input  vstu_pkg::vl_t       req_vl_i,
  input  vstu_pkg::vsew_e     req_vsew_i,
  output logic                req_ready_o,
  // Issue head towards the packer
  output logic                issue_valid_o,
  output vstu_pkg::vinsn_id_t issue_id_o,
  output vstu_pkg::byte_cnt_t issue_bytes_o,
  input  logic                issue_done_i,
  // Retire from the commit stage
  input  logic                commit_i,
  input  vstu_pkg::vinsn_id_t commit_id_i,
  output logic                store_pending_o
);

  import vstu_pkg::*;

  ////////////////////////////////////////
  // Queue storage
  ////////////////////////////////////////

  // Payload of each slot
  vinsn_id_t id_q    [QueueDepth];
  byte_cnt_t bytes_q [QueueDepth];

  // Accept and issue pointers
  qidx_t accept_pnt_q;
  qidx_t issue_pnt_q;
  // Accepted but not yet fully issued
  qcnt_t issue_cnt_q;
  // Accepted but not yet retired
  qcnt_t inflight_q;

  // One bit per id that is still in flight
  logic [NrVInsn-1:0] running_q;

  logic      accept;
  byte_cnt_t req_bytes;

  // Full when every slot waits for a write response
  assign req_ready_o = (inflight_q != qcnt_t'(QueueDepth));

  // Only stores, and never an id that is still running
  assign accept = req_valid_i && req_ready_o &&
                  (req_op_i == OP_STORE) && !running_q[req_id_i];

  // Byte count is vl scaled by the element size
  assign req_bytes = byte_cnt_t'(req_vl_i) << req_vsew_i;

  // Head of the issue pointer
  assign issue_valid_o   = (issue_cnt_q != '0);
  assign issue_id_o      = id_q[issue_pnt_q];
  assign issue_bytes_o   = bytes_q[issue_pnt_q];
  assign store_pending_o = (inflight_q != '0);

  // Slot write on accept
  always_ff @(posedge clk_i) begin
    if (accept) begin
      id_q[accept_pnt_q]    <= req_id_i;
      bytes_q[accept_pnt_q] <= req_bytes;
    end
  end

  ////////////////////////////////////////
  // Pointers and counters
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      issue_cnt_q  <= '0;
      inflight_q   <= '0;
      running_q    <= '0;
    end else begin
      if (accept) begin
        accept_pnt_q <= accept_pnt_q + 1'b1;
      end
      // Next head streams from the following cycle
      if (issue_done_i) begin
        issue_pnt_q <= issue_pnt_q + 1'b1;
      end
      // Both counters may move up and down in one cycle
      issue_cnt_q <= issue_cnt_q + qcnt_t'(accept) - qcnt_t'(issue_done_i);
      inflight_q  <= inflight_q + qcnt_t'(accept) - qcnt_t'(commit_i);
      // Retired id is free again from the next cycle
      if (commit_i) begin
        running_q[commit_id_i] <= 1'b0;
      end
      if (accept) begin
        running_q[req_id_i] <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/vstu_pkg.sv
`default_nettype none

package vstu_pkg;

  ////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////

  // Lanes feeding the store unit
  localparam int unsigned NrLanes    = 4;
  // Bytes in one lane operand word
  localparam int unsigned LaneBytes  = 8;
  // Bytes in one full set of lane words
  localparam int unsigned WordBytes  = NrLanes * LaneBytes;
  // Bytes in one write beat
  localparam int unsigned BeatBytes  = 8;
  // Store instructions held between accept and commit
  localparam int unsigned QueueDepth = 4;
  // Distinct instruction ids
  localparam int unsigned NrVInsn    = 8;
  localparam int unsigned VlWidth    = 12;
  // Vector length shifted by up to 3 for SEW64
  localparam int unsigned BytesWidth = VlWidth + 3;
  localparam int unsigned LenWidth   = 8;

  // Derived widths
  localparam int unsigned IdWidth      = $clog2(NrVInsn);
  localparam int unsigned QidxWidth    = $clog2(QueueDepth);
  localparam int unsigned QcntWidth    = QidxWidth + 1;
  localparam int unsigned LaneIdxWidth = $clog2(NrLanes);

  ////////////////////////////////////////
  // Types
  ////////////////////////////////////////

  typedef logic [8*LaneBytes-1:0]  elen_t;
  typedef logic [8*BeatBytes-1:0]  beat_data_t;
  typedef logic [BeatBytes-1:0]    beat_strb_t;
  typedef logic [IdWidth-1:0]      vinsn_id_t;
  typedef logic [VlWidth-1:0]      vl_t;
  typedef logic [BytesWidth-1:0]   byte_cnt_t;
  // Number of beats minus one
  typedef logic [LenWidth-1:0]     burst_len_t;
  typedef logic [QidxWidth-1:0]    qidx_t;
  typedef logic [QcntWidth-1:0]    qcnt_t;
  typedef logic [LaneIdxWidth-1:0] lane_idx_t;

  // Target unit of a sequencer request
  typedef enum logic [1:0] {
    OP_STORE,
    OP_LOAD,
    OP_ALU,
    OP_MASK
  } vfu_op_e;

  // Element width, value is the byte shift
  typedef enum logic [1:0] {
    SEW8  = 2'd0,
    SEW16 = 2'd1,
    SEW32 = 2'd2,
    SEW64 = 2'd3
  } vsew_e;

  typedef enum logic {
    PH_IDLE,
    PH_STREAM
  } pack_phase_e;

endpackage

`default_nettype wire
